// File: oledCanvas.f
+incdir+tb
logic/oledPkg.sv
logic/pixelMapper.sv
logic/pixelPlotter.sv
logic/refreshScanner.sv
logic/frameBuffer.sv
logic/oledCanvas.sv
tb/oledCanvasTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module oledCanvasTb -f oledCanvas.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VoledCanvasTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1

// File: tb/canvasVectors.svh
`ifndef CANVAS_VECTORS_SVH
`define CANVAS_VECTORS_SVH

// Directed plot commands and the byte each one must hit
// Columns: column, row, operation, expected page, expected mask (zero when out of range)
typedef struct packed {
	logic [7:0] column;
	logic [7:0] row;
	oledPkg::plotOpT op;
	logic [2:0] page;
	logic [7:0] mask;
} vecT;

localparam int VEC_COUNT = 21;

localparam vecT VECTORS [VEC_COUNT] = '{
	{8'd0, 8'd0, oledPkg::opSet, 3'd7, 8'h80},
	{8'd127, 8'd0, oledPkg::opSet, 3'd7, 8'h80},
	{8'd0, 8'd7, oledPkg::opSet, 3'd7, 8'h01},
	{8'd127, 8'd7, oledPkg::opSet, 3'd7, 8'h01},
	{8'd0, 8'd8, oledPkg::opSet, 3'd6, 8'h80},
	{8'd5, 8'd8, oledPkg::opToggle, 3'd6, 8'h80},
	{8'd5, 8'd8, oledPkg::opToggle, 3'd6, 8'h80},
	{8'd127, 8'd56, oledPkg::opSet, 3'd0, 8'h80},
	{8'd127, 8'd63, oledPkg::opSet, 3'd0, 8'h01},
	{8'd0, 8'd63, oledPkg::opToggle, 3'd0, 8'h01},
	{8'd0, 8'd63, oledPkg::opClear, 3'd0, 8'h01},
	{8'd64, 8'd7, oledPkg::opSet, 3'd7, 8'h01},
	{8'd64, 8'd7, oledPkg::opClear, 3'd7, 8'h01},
	{8'd127, 8'd0, oledPkg::opClear, 3'd7, 8'h80},
	{8'd3, 8'd56, oledPkg::opToggle, 3'd0, 8'h80},
	{8'd10, 8'd9, oledPkg::opSet, 3'd6, 8'h40},
	// Out of range, no byte may change
	{8'd0, 8'd64, oledPkg::opSet, 3'd0, 8'h00},
	{8'd128, 8'd0, oledPkg::opSet, 3'd0, 8'h00},
	{8'd255, 8'd255, oledPkg::opToggle, 3'd0, 8'h00},
	{8'd127, 8'd200, oledPkg::opClear, 3'd0, 8'h00},
	{8'd200, 8'd10, oledPkg::opToggle, 3'd0, 8'h00}
};

`endif

// File: tb/oledCanvasTb.sv
`timescale 1ns/10ps

module oledCanvasTb;

	localparam int COLUMNS = 128;
	localparam int PAGES = 8;
	localparam int QUEUE_DEPTH = 4;
	localparam int FRAME_BYTES = COLUMNS * PAGES;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CMDS = 200;
	localparam int REFRESHES = 3;
	localparam int DRAIN_LIMIT = 40 * QUEUE_DEPTH;

	`include "canvasVectors.svh"

	// Reset time includes the clear sweep of the page memory
	localparam int CYCLE_LIMIT = 40 * (VEC_COUNT + RANDOM_CMDS) + 4 * FRAME_BYTES * REFRESHES
		+ RESET_CYCLES + FRAME_BYTES;

	logic clk;
	logic reset;
	logic cmdValid;
	oledPkg::plotCmdT cmd;
	logic cmdCredit;
	logic frameStart;
	logic pixCredit;
	logic pixValid;
	logic [7:0] pixData;
	logic frameDone;

	logic [7:0] model [PAGES][COLUMNS];
	logic [15:0] lfsr;
	int credits;
	int sent;
	int returned;
	int byteCount;
	int pixGiven;
	int pixSeen;
	bit frameSeen;
	int cycles;
	int mismatches;
	int failures;

	oledCanvas #(.COLUMNS(COLUMNS), .PAGES(PAGES), .QUEUE_DEPTH(QUEUE_DEPTH)) DUT (.*);

	always #10 clk = ~clk;

	task automatic checkValue(input string name, input int actual, input int expected);
		if (actual != expected) begin
			mismatches++;
			$display("mismatch at %0t: %s is %0h, expected %0h",
				$time, name, actual, expected);
		end
	endtask

	task automatic reportFailure(input string what);
		failures++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [7:0] randomBits(input int n);
		logic [7:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			value = {value[6:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic void applyModel(input logic [2:0] page, input logic [6:0] column,
			input logic [7:0] mask, input oledPkg::plotOpT op);
		case (op)
			oledPkg::opSet: model[page][column] = model[page][column] | mask;
			oledPkg::opClear: model[page][column] = model[page][column] & ~mask;
			default: model[page][column] = model[page][column] ^ mask;
		endcase
	endfunction

	// Lowest band sits in page 0 with the top row of a band in the MSB
	function automatic void plotModel(input logic [7:0] column, input logic [7:0] row,
			input oledPkg::plotOpT op);
		if (int'(row) >= 8 * PAGES || int'(column) >= COLUMNS)
			return;
		applyModel(3'(PAGES - 1 - int'(row) / 8), column[6:0], 8'h80 >> row[2:0], op);
	endfunction

	////////////////////
	// Driver
	////////////////////

	task automatic sendCmd(input logic [7:0] column, input logic [7:0] row,
			input oledPkg::plotOpT op);
		while (credits == 0)
			@(negedge clk);
		cmd.column = column;
		cmd.row = row;
		cmd.op = op;
		cmdValid = 1'b1;
		credits--;
		sent++;
		@(negedge clk);
		cmdValid = 1'b0;
	endtask

	// Bounded wait so a lost credit shows up as a wrong count
	task automatic drainQueue();
		int waited;
		waited = 0;
		while (returned != sent && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		checkValue("cmdCredit count", returned, sent);
	endtask

	// Gives one frame's worth of output credits that the LFSR gates when throttled
	task automatic runRefresh(input bit throttle);
		int given;
		given = 0;
		byteCount = 0;
		frameSeen = 1'b0;
		frameStart = 1'b1;
		@(negedge clk);
		frameStart = 1'b0;
		while (!frameSeen) begin
			pixCredit = (given < FRAME_BYTES) && (!throttle || randomBits(1) != 0);
			if (pixCredit)
				given++;
			@(negedge clk);
		end
		pixCredit = 1'b0;
		checkValue("bytes per frame", byteCount, FRAME_BYTES);
	endtask

	////////////////////
	// Monitor
	////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			if (cmdCredit) begin
				credits++;
				returned++;
				if (credits > QUEUE_DEPTH)
					reportFailure("more command credits came back than were sent");
			end
			if (pixCredit)
				pixGiven++;
			if (pixValid) begin
				pixSeen++;
				if (pixSeen > pixGiven)
					reportFailure("pixValid came without an output credit");
				if (byteCount >= FRAME_BYTES)
					reportFailure("more bytes than one frame");
				else
					checkValue("pixData", pixData,
						model[byteCount / COLUMNS][byteCount % COLUMNS]);
				byteCount++;
			end
			if (frameDone) begin
				checkValue("pixValid with frameDone", pixValid, 1);
				checkValue("frameDone position", byteCount, FRAME_BYTES);
				frameSeen = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		vecT vec;
		logic [1:0] opBits;
		clk = 1'b0;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmd = '0;
		frameStart = 1'b0;
		pixCredit = 1'b0;
		lfsr = 16'd28;
		credits = QUEUE_DEPTH;
		foreach (model[p, c])
			model[p][c] = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		repeat (4) begin
			@(negedge clk);
			checkValue("cmdCredit", cmdCredit, 0);
			checkValue("pixValid", pixValid, 0);
			checkValue("frameDone", frameDone, 0);
		end
		runRefresh(1'b0);

		for (int i = 0; i < VEC_COUNT; i++) begin
			vec = VECTORS[i];
			sendCmd(vec.column, vec.row, vec.op);
			if (vec.mask != 0)
				applyModel(vec.page, vec.column[6:0], vec.mask, vec.op);
		end
		drainQueue();
		runRefresh(1'b1);

		// Mostly back to back with a short gap now and then
		for (int i = 0; i < RANDOM_CMDS; i++) begin
			vec.column = randomBits(8);
			vec.row = randomBits(7);
			opBits = 2'(randomBits(2));
			vec.op = (opBits == 2'd3) ? oledPkg::opToggle : oledPkg::plotOpT'(opBits);
			sendCmd(vec.column, vec.row, vec.op);
			plotModel(vec.column, vec.row, vec.op);
			if (randomBits(3) == 0)
				repeat (int'(randomBits(3))) @(negedge clk);
		end
		drainQueue();
		runRefresh(1'b1);

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: logic/oledCanvas.sv
`timescale 1ns/10ps

module oledCanvas #(
	parameter int COLUMNS = 128,
	parameter int PAGES = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input oledPkg::plotCmdT cmd,
	output logic cmdCredit,
	input logic frameStart,
	input logic pixCredit,
	output logic pixValid,
	output logic [7:0] pixData,
	output logic frameDone
);

	logic plotReqValid;
	oledPkg::memReqT plotReq;
	logic plotGrant;
	logic scanReqValid;
	oledPkg::memReqT scanReq;
	logic scanGrant;

	// Shared by both readers
	logic [7:0] rdData;

	pixelPlotter #(
		.COLUMNS(COLUMNS),
		.PAGES(PAGES),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) plotter (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdCredit(cmdCredit),
		.plotReqValid(plotReqValid),
		.plotReq(plotReq),
		.plotGrant(plotGrant),
		.rdData(rdData)
	);

	refreshScanner #(
		.COLUMNS(COLUMNS),
		.PAGES(PAGES)
	) scanner (
		.clk(clk),
		.reset(reset),
		.frameStart(frameStart),
		.pixCredit(pixCredit),
		.scanReqValid(scanReqValid),
		.scanReq(scanReq),
		.scanGrant(scanGrant),
		.rdData(rdData),
		.pixValid(pixValid),
		.pixData(pixData),
		.frameDone(frameDone)
	);

	frameBuffer #(
		.COLUMNS(COLUMNS),
		.PAGES(PAGES)
	) buffer (
		.clk(clk),
		.reset(reset),
		.plotReqValid(plotReqValid),
		.plotReq(plotReq),
		.plotGrant(plotGrant),
		.scanReqValid(scanReqValid),
		.scanReq(scanReq),
		.scanGrant(scanGrant),
		.rdData(rdData)
	);

endmodule

// File: logic/frameBuffer.sv
`timescale 1ns/10ps

module frameBuffer #(
	parameter int COLUMNS = 128,
	parameter int PAGES = 8
) (
	input logic clk,
	input logic reset,
	input logic plotReqValid,
	input oledPkg::memReqT plotReq,
	output logic plotGrant,
	input logic scanReqValid,
	input oledPkg::memReqT scanReq,
	output logic scanGrant,
	output logic [7:0] rdData
);

	localparam int DEPTH = COLUMNS * PAGES;
	localparam int ADDR_W = $clog2(DEPTH);

	logic [7:0] mem [DEPTH];

	// Clear sweep after reset
	logic sweeping;
	logic [ADDR_W-1:0] sweepAddr;

	oledPkg::memReqT selReq;
	logic selValid;
	logic [ADDR_W-1:0] selAddr;

	////////////////////
	// Arbitration
	////////////////////

	// Scanner first, nothing while the clear sweep runs
	assign scanGrant = !sweeping && scanReqValid;
	assign plotGrant = !sweeping && plotReqValid && !scanReqValid;

	assign selValid = scanGrant || plotGrant;
	assign selReq = scanGrant ? scanReq : plotReq;
	assign selAddr = ADDR_W'(selReq.page) * ADDR_W'(COLUMNS) + ADDR_W'(selReq.column);

	always_ff @(posedge clk) begin
		if (reset) begin
			sweeping <= 1'b1;
			sweepAddr <= '0;
		end else if (sweeping) begin
			if (sweepAddr == ADDR_W'(DEPTH - 1))
				sweeping <= 1'b0;
			sweepAddr <= sweepAddr + 1'b1;
		end
	end

	////////////////////
	// Page memory
	////////////////////

	always_ff @(posedge clk) begin
		if (sweeping)
			mem[sweepAddr] <= '0;
		else if (selValid && selReq.write)
			mem[selAddr] <= selReq.wrData;

		// One cycle read latency
		if (selValid && !selReq.write)
			rdData <= mem[selAddr];
	end

endmodule

// File: logic/refreshScanner.sv
`timescale 1ns/10ps

module refreshScanner #(
	parameter int COLUMNS = 128,
	parameter int PAGES = 8
) (
	input logic clk,
	input logic reset,
	input logic frameStart,
	input logic pixCredit,
	output logic scanReqValid,
	output oledPkg::memReqT scanReq,
	input logic scanGrant,
	input logic [7:0] rdData,
	output logic pixValid,
	output logic [7:0] pixData,
	output logic frameDone
);

	localparam int FRAME_BYTES = COLUMNS * PAGES;
	localparam int CREDIT_W = $clog2(FRAME_BYTES + 1) + 1;

	typedef enum logic [1:0] {
		scanIdle,
		scanPrime,
		scanRun
	} scanStateT;

	scanStateT state;

	logic [2:0] issuePage;
	logic [6:0] issueColumn;
	logic issueDone;
	logic lastAddr;
	logic issue;

	// Granted read whose byte goes out this cycle
	logic rdPending;
	logic lastPending;

	// Bytes the sink can still accept
	logic [CREDIT_W-1:0] credits;

	assign lastAddr = (issuePage == 3'(PAGES - 1)) && (issueColumn == 7'(COLUMNS - 1));

	// A read is only issued against a credit not yet spoken for
	assign scanReqValid = (state == scanRun) && !issueDone
		&& (credits > CREDIT_W'(rdPending));
	assign issue = scanReqValid && scanGrant;

	assign scanReq.page = issuePage;
	assign scanReq.column = issueColumn;
	assign scanReq.write = 1'b0;
	assign scanReq.wrData = '0;

	assign pixValid = rdPending;
	assign pixData = rdData;
	assign frameDone = rdPending && lastPending;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= scanIdle;
			issuePage <= '0;
			issueColumn <= '0;
			issueDone <= 1'b0;
			rdPending <= 1'b0;
			lastPending <= 1'b0;
			credits <= '0;
		end else begin
			rdPending <= issue;
			lastPending <= issue && lastAddr;
			credits <= credits + CREDIT_W'(pixCredit) - CREDIT_W'(pixValid);

			case (state)
				// frameStart is only seen here, so a running refresh ignores it
				scanIdle: begin
					if (frameStart)
						state <= scanPrime;
				end
				scanPrime: begin
					issuePage <= '0;
					issueColumn <= '0;
					issueDone <= 1'b0;
					state <= scanRun;
				end
				scanRun: begin
					if (issue) begin
						if (lastAddr) begin
							issueDone <= 1'b1;
						end else if (issueColumn == 7'(COLUMNS - 1)) begin
							issueColumn <= '0;
							issuePage <= issuePage + 1'b1;
						end else begin
							issueColumn <= issueColumn + 1'b1;
						end
					end
					if (frameDone)
						state <= scanIdle;
				end
				default: state <= scanIdle;
			endcase
		end
	end

endmodule

// File: logic/pixelPlotter.sv
`timescale 1ns/10ps

module pixelPlotter #(
	parameter int COLUMNS = 128,
	parameter int PAGES = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input oledPkg::plotCmdT cmd,
	output logic cmdCredit,
	output logic plotReqValid,
	output oledPkg::memReqT plotReq,
	input logic plotGrant,
	input logic [7:0] rdData
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [1:0] {
		plotIdle,
		plotRead,
		plotWait,
		plotWrite
	} plotStateT;

	plotStateT state;

	oledPkg::plotCmdT queue [QUEUE_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [COUNT_W-1:0] count;
	logic push;
	logic pop;

	oledPkg::plotCmdT head;
	logic [2:0] headPage;
	logic [6:0] headColumn;
	logic [7:0] headMask;
	logic headInRange;

	// Target of the command in progress
	logic [2:0] curPage;
	logic [6:0] curColumn;
	logic [7:0] curMask;
	oledPkg::plotOpT curOp;
	logic [7:0] newByte;

	function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	function automatic logic [7:0] applyOp(oledPkg::plotOpT op, logic [7:0] data,
			logic [7:0] mask);
		case (op)
			oledPkg::opSet: return data | mask;
			oledPkg::opClear: return data & ~mask;
			oledPkg::opToggle: return data ^ mask;
			default: return data;
		endcase
	endfunction

	////////////////////
	// Command queue
	////////////////////

	assign push = cmdValid && (count != COUNT_W'(QUEUE_DEPTH));
	assign pop = (state == plotIdle) && (count != '0);
	assign head = queue[rdPtr];

	always_ff @(posedge clk) begin
		if (push)
			queue[wrPtr] <= cmd;
	end

	pixelMapper #(
		.COLUMNS(COLUMNS),
		.PAGES(PAGES)
	) mapper (
		.column(head.column),
		.row(head.row),
		.page(headPage),
		.memColumn(headColumn),
		.bitMask(headMask),
		.inRange(headInRange)
	);

	////////////////////
	// Read-modify-write
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			state <= plotIdle;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			case (state)
				// Out of range commands are dropped here
				plotIdle: if (pop && headInRange) state <= plotRead;
				plotRead: if (plotGrant) state <= plotWait;
				plotWait: state <= plotWrite;
				plotWrite: if (plotGrant) state <= plotIdle;
				default: state <= plotIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			curPage <= headPage;
			curColumn <= headColumn;
			curMask <= headMask;
			curOp <= head.op;
		end
		// Read data arrives the cycle after the read grant
		if (state == plotWait)
			newByte <= applyOp(curOp, rdData, curMask);
	end

	assign plotReqValid = (state == plotRead) || (state == plotWrite);
	assign plotReq.page = curPage;
	assign plotReq.column = curColumn;
	assign plotReq.write = (state == plotWrite);
	assign plotReq.wrData = newByte;

	assign cmdCredit = (pop && !headInRange) || ((state == plotWrite) && plotGrant);

endmodule

// File: logic/pixelMapper.sv
`timescale 1ns/10ps

module pixelMapper #(
	parameter int COLUMNS = 128,
	parameter int PAGES = 8
) (
	input logic [7:0] column,
	input logic [7:0] row,
	output logic [2:0] page,
	output logic [6:0] memColumn,
	output logic [7:0] bitMask,
	output logic inRange
);

	logic [7:0] band;
	logic [2:0] rowInBand;

	always_comb begin
		band = row / 8'(oledPkg::PAGE_ROWS);
		rowInBand = 3'(row % 8'(oledPkg::PAGE_ROWS));
		inRange = (int'(row) < PAGES * oledPkg::PAGE_ROWS) && (int'(column) < COLUMNS);
		memColumn = column[6:0];

		// Top band lives in the last page, top row in the MSB
		if (inRange) begin
			page = 3'(PAGES - 1 - int'(band));
			bitMask = 8'h80 >> rowInBand;
		end else begin
			page = '0;
			bitMask = '0;
		end
	end

endmodule

// File: logic/oledPkg.sv
package oledPkg;

	////////////////////
	// Panel organization
	////////////////////

	// One page is a band of eight rows, one byte per column
	localparam int PAGE_ROWS = 8;

	////////////////////
	// Plot commands
	////////////////////

	typedef enum logic [1:0] {
		opSet = 2'd0,
		opClear = 2'd1,
		opToggle = 2'd2
	} plotOpT;

	typedef struct packed {
		logic [7:0] column;
		logic [7:0] row;
		plotOpT op;
	} plotCmdT;

	////////////////////
	// Page memory access
	////////////////////

	// Write data is ignored on reads
	typedef struct packed {
		logic [2:0] page;
		logic [6:0] column;
		logic write;
		logic [7:0] wrData;
	} memReqT;

endpackage
